/* sim.f */
hdl/softreg_pkg.sv
hdl/app_reg_bank.sv
hdl/sr_entry.sv
hdl/sr_req_fifo.sv
hdl/sr_route.sv
hdl/softreg_top.sv
verif/tb_softreg.sv

/* Makefile */
# Verilator build and run of the soft-register control path

LOG := sim.log

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing -f sim.f --top-module tb_softreg -o Vtb_softreg
	./obj_dir/Vtb_softreg | tee $(LOG)
	grep -q "^PASS: all tests$$" $(LOG)

lint:
	verilator --lint-only -Wall -f sim.f --top-module softreg_top

clean:
	rm -rf obj_dir $(LOG)

/* verif/tb_softreg.sv */
/*
	Testbench for the soft-register control path

	Drives directed and random reads and writes into softreg_top under
	random response back-pressure. Every read response is checked in
	issue order against a register model kept in the testbench.
*/

`timescale 1ns/1ps
`default_nettype none

module tb_softreg import softreg_pkg::*; ();

	localparam int NUM_APPS     = 4;
	localparam int REGS_PER_APP = 8;
	localparam int FIFO_DEPTH   = 4;
	localparam int NUM_REGS     = NUM_APPS * REGS_PER_APP;
	localparam logic [31:0] SEED = 32'hdb71_fc9e;
	localparam int TIMEOUT      = 400;

	logic                 global_clk;
	logic                 rst_n;
	logic                 req_valid;
	logic                 req_write;
	logic [SR_ADDR_W-1:0] req_addr;
	logic [SR_DATA_W-1:0] req_wdata;
	logic                 req_ready;
	logic                 resp_ready;
	logic                 resp_valid;
	logic [SR_DATA_W-1:0] resp_rdata;

	logic [SR_DATA_W-1:0] model [NUM_REGS];
	logic [SR_DATA_W-1:0] exp_q [$];
	logic [31:0]          req_lcg;
	logic [31:0]          rdy_lcg;
	logic                 held;
	logic [SR_DATA_W-1:0] held_data;
	int                   rdy_mode;
	int                   err_count;
	int                   timeout_count;
	int                   resp_count;

	softreg_top #(
		.NUM_APPS(NUM_APPS), .REGS_PER_APP(REGS_PER_APP), .FIFO_DEPTH(FIFO_DEPTH)
	) dut0 (
		.global_clk(global_clk), .rst_n(rst_n),
		.req_valid(req_valid), .req_write(req_write), .req_addr(req_addr),
		.req_wdata(req_wdata), .req_ready(req_ready),
		.resp_ready(resp_ready), .resp_valid(resp_valid), .resp_rdata(resp_rdata)
	);

	always #5 global_clk = ~global_clk;

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [31:0] next_rand();
		req_lcg = lcg_step(req_lcg);
		return req_lcg;
	endfunction

	task automatic check_data(input logic [SR_DATA_W-1:0] got,
			input logic [SR_DATA_W-1:0] exp, input string what);
		if (got !== exp) begin
			err_count++;
			$display("[ERROR] %0t ns: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			err_count++;
			$display("[ERROR] %0t ns: %s got %b expected %b", $time, what, got, exp);
		end
	endtask

	// Starts and ends on a falling edge; the model moves at acceptance
	task automatic try_req(input logic wr, input logic [SR_ADDR_W-1:0] addr,
			input logic [SR_DATA_W-1:0] data, input int limit, output logic ok);
		int waited;
		int flat;
		ok     = 1'b0;
		waited = 0;
		flat   = ((addr / REGS_PER_APP) % NUM_APPS) * REGS_PER_APP + addr % REGS_PER_APP;
		req_valid = 1'b1;
		req_write = wr;
		req_addr  = addr;
		req_wdata = data;
		while (!ok && waited < limit) begin
			if (req_ready) begin
				@(posedge global_clk);
				ok = 1'b1;
				if (wr) begin
					model[flat] = data;
				end else begin
					exp_q.push_back(model[flat]);
				end
			end else begin
				waited++;
			end
			@(negedge global_clk);
		end
		req_valid = 1'b0;
	endtask

	task automatic send_req(input logic wr, input logic [SR_ADDR_W-1:0] addr,
			input logic [SR_DATA_W-1:0] data);
		logic ok;
		try_req(wr, addr, data, TIMEOUT, ok);
		if (!ok) begin
			timeout_count++;
			$display("Timeout: request to address %h was never accepted", addr);
		end
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		while ((exp_q.size() != 0 || resp_valid) && waited < TIMEOUT) begin
			@(negedge global_clk);
			waited++;
		end
		if (exp_q.size() != 0 || resp_valid) begin
			timeout_count++;
			$display("Timeout: %0d read responses never arrived", exp_q.size());
		end
	endtask

	//----------------------------------------------------------------------
	// Random resp_ready with ordering and hold checks on the response side
	//----------------------------------------------------------------------
	always @(negedge global_clk) begin
		if (rst_n) begin
			if (held) begin
				check_bit(resp_valid, 1'b1, "resp_valid while stalled");
				check_data(resp_rdata, held_data, "resp_rdata while stalled");
			end
			rdy_lcg = lcg_step(rdy_lcg);
			case (rdy_mode)
				0:       resp_ready = rdy_lcg[17];
				1:       resp_ready = 1'b1;
				default: resp_ready = 1'b0;
			endcase
			if (resp_valid && resp_ready) begin
				resp_count++;
				if (exp_q.size() == 0) begin
					err_count++;
					$display("A read response arrived with no read outstanding at %0t ns", $time);
				end else begin
					check_data(resp_rdata, exp_q.pop_front(), "read data");
				end
			end
			held      = resp_valid && !resp_ready;
			held_data = resp_rdata;
		end
	end

	initial begin
		logic        ok;
		logic [31:0] r;
		int          accepted;
		int          waited;
		global_clk = 1'b0;
		rst_n      = 1'b0;
		req_valid  = 1'b0;
		req_write  = 1'b0;
		req_addr   = '0;
		req_wdata  = '0;
		resp_ready = 1'b0;
		req_lcg    = SEED;
		rdy_lcg    = lcg_step(SEED);
		held       = 1'b0;
		held_data  = '0;
		rdy_mode   = 1;
		err_count  = 0;
		timeout_count = 0;
		resp_count = 0;
		for (int i = 0; i < NUM_REGS; i++) begin
			model[i] = '0;
		end
		repeat (8) @(posedge global_clk);
		@(negedge global_clk);
		rst_n = 1'b1;

		// Reset values and zero readback of every register
		check_bit(req_ready, 1'b1, "req_ready after reset");
		check_bit(resp_valid, 1'b0, "resp_valid after reset");
		for (int i = 0; i < NUM_REGS; i++) begin
			send_req(1'b0, 32'(i), '0);
		end
		wait_drain();

		// Directed readback across applications and aliased addresses
		send_req(1'b1, 32'h5, 64'hdead_beef_0123_4567);
		send_req(1'b0, 32'h5, '0);
		for (int a = 0; a < NUM_APPS; a++) begin
			send_req(1'b1, 32'(a * REGS_PER_APP + 3), {32'hA5A5_0000, 32'(a)});
		end
		for (int a = 0; a < NUM_APPS; a++) begin
			send_req(1'b0, 32'(a * REGS_PER_APP + 3), '0);
		end
		send_req(1'b1, 32'h22, 64'h1122_3344_5566_7788);
		send_req(1'b0, 32'(32'h22 + NUM_REGS * 5), '0);
		send_req(1'b0, 32'h8000_0022, '0);
		wait_drain();

		// Random traffic with random back-pressure
		rdy_mode = 0;
		repeat (300) begin
			r = next_rand();
			send_req(r[20], {r[31:28], 20'h0, r[15:8]}, {next_rand(), next_rand()});
			if (r[24:23] == 2'b00) begin
				@(negedge global_clk);
			end
		end
		wait_drain();

		// Host stalls responses until the credits run out
		rdy_mode = 2;
		@(negedge global_clk);
		send_req(1'b0, 32'h3, '0);
		accepted = 0;
		ok = 1'b1;
		while (ok && accepted <= FIFO_DEPTH + 2) begin
			try_req(1'b0, 32'(accepted + 8), '0, 20, ok);
			if (ok) begin
				accepted++;
			end
		end
		if (accepted > FIFO_DEPTH + 2) begin
			err_count++;
			$display("[ERROR] %0t ns: %0d requests accepted while stalled", $time, accepted);
		end
		check_bit(req_ready, 1'b0, "req_ready while stalled");
		rdy_mode = 1;
		waited = 0;
		while (!req_ready && waited < TIMEOUT) begin
			@(negedge global_clk);
			waited++;
		end
		if (!req_ready) begin
			timeout_count++;
			$display("Timeout: req_ready never came back after the stall");
		end
		wait_drain();

		$display("Done: %0d responses, %0d errors, %0d timeouts", resp_count, err_count,
			timeout_count);
		if (err_count == 0 && timeout_count == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* hdl/softreg_top.sv */
/*
	Soft-register control path, top level

	Host requests pass through the entry stage and the request FIFO to
	the routing stage, which owns the application register banks and
	returns read data in order. Sets the sizing parameters.
*/

`timescale 1ns/1ps
`default_nettype none

module softreg_top import softreg_pkg::*; #(
	parameter int NUM_APPS     = 4,
	parameter int REGS_PER_APP = 8,
	parameter int FIFO_DEPTH   = 4
) (
	input  wire logic                 global_clk,
	input  wire logic                 rst_n,
	// Host request port
	input  wire logic                 req_valid,
	input  wire logic                 req_write,
	input  wire logic [SR_ADDR_W-1:0] req_addr,
	input  wire logic [SR_DATA_W-1:0] req_wdata,
	output logic                      req_ready,
	// Host response port
	input  wire logic                 resp_ready,
	output logic                      resp_valid,
	output logic [SR_DATA_W-1:0]      resp_rdata
);

	// Entry stage to FIFO
	logic                 push;
	sr_op_e               push_op;
	logic [SR_ADDR_W-1:0] push_addr;
	logic [SR_DATA_W-1:0] push_wdata;

	// FIFO to routing stage
	logic                 fifo_valid;
	sr_op_e               head_op;
	logic [SR_ADDR_W-1:0] head_addr;
	logic [SR_DATA_W-1:0] head_wdata;
	logic                 pop;
	logic                 credit_return;

	sr_entry #(.FIFO_DEPTH(FIFO_DEPTH)) entry0 (
		.global_clk(global_clk), .rst_n(rst_n),
		.req_valid(req_valid), .req_write(req_write), .req_addr(req_addr),
		.req_wdata(req_wdata), .req_ready(req_ready), .credit_return(credit_return),
		.push(push), .push_op(push_op), .push_addr(push_addr), .push_wdata(push_wdata)
	);

	sr_req_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) fifo0 (
		.global_clk(global_clk), .rst_n(rst_n),
		.push(push), .push_op(push_op), .push_addr(push_addr), .push_wdata(push_wdata),
		.pop(pop), .fifo_valid(fifo_valid), .head_op(head_op), .head_addr(head_addr),
		.head_wdata(head_wdata)
	);

	sr_route #(.NUM_APPS(NUM_APPS), .REGS_PER_APP(REGS_PER_APP)) route0 (
		.global_clk(global_clk), .rst_n(rst_n),
		.fifo_valid(fifo_valid), .head_op(head_op), .head_addr(head_addr),
		.head_wdata(head_wdata), .pop(pop), .credit_return(credit_return),
		.resp_ready(resp_ready), .resp_valid(resp_valid), .resp_rdata(resp_rdata)
	);

endmodule

`default_nettype wire

/* hdl/sr_route.sv */
/*
	Soft-register routing stage

	Pops requests from the FIFO, picks the application bank from the
	address and performs the access. Writes go through a one-cycle
	write register into the bank. Reads load a response register that
	is held until the host takes it; pops stop while it waits.
*/

`timescale 1ns/1ps
`default_nettype none

module sr_route import softreg_pkg::*; #(
	parameter int NUM_APPS     = 4,
	parameter int REGS_PER_APP = 8
) (
	input  wire logic                 global_clk,
	input  wire logic                 rst_n,
	// FIFO head
	input  wire logic                 fifo_valid,
	input  wire sr_op_e               head_op,
	input  wire logic [SR_ADDR_W-1:0] head_addr,
	input  wire logic [SR_DATA_W-1:0] head_wdata,
	output logic                      pop,
	output logic                      credit_return,
	// Host response port
	input  wire logic                 resp_ready,
	output logic                      resp_valid,
	output logic [SR_DATA_W-1:0]      resp_rdata
);

	localparam int IDX_W = (REGS_PER_APP > 1) ? $clog2(REGS_PER_APP) : 1;
	localparam int APP_W = (NUM_APPS > 1) ? $clog2(NUM_APPS) : 1;

	sr_route_state_e    state;
	logic [IDX_W-1:0]   head_idx;
	logic [APP_W-1:0]   head_app;
	logic               hold_busy;
	logic               wr_pend;
	logic [APP_W-1:0]   wr_app;
	logic [IDX_W-1:0]   wr_idx;
	logic [SR_DATA_W-1:0] wr_data;
	logic [IDX_W-1:0]   bank_idx;
	logic [SR_DATA_W-1:0] bank_rd [NUM_APPS];

	// Register index below, application index above, rest ignored
	assign head_idx = IDX_W'(head_addr % REGS_PER_APP);
	assign head_app = APP_W'((head_addr / REGS_PER_APP) % NUM_APPS);

	// A read waits one cycle behind a write still going into a bank
	assign hold_busy     = (state == ROUTE_RESP_HOLD) && !resp_ready;
	assign pop           = fifo_valid && !hold_busy && !(wr_pend && head_op == SR_OP_READ);
	assign credit_return = pop;
	assign resp_valid    = (state == ROUTE_RESP_HOLD);

	//----------------------------------------------------------------------
	// Response FSM
	//----------------------------------------------------------------------
	always_ff @(posedge global_clk or negedge rst_n) begin
		if (!rst_n) begin
			state   <= ROUTE_IDLE;
			wr_pend <= 1'b0;
		end else begin
			if (pop && head_op == SR_OP_READ) begin
				state <= ROUTE_RESP_HOLD;
			end else if (resp_ready) begin
				state <= ROUTE_IDLE;
			end
			wr_pend <= pop && (head_op == SR_OP_WRITE);
		end
	end

	// Read data and pending write payload
	always_ff @(posedge global_clk) begin
		if (pop && head_op == SR_OP_READ) begin
			resp_rdata <= bank_rd[head_app];
		end
		if (pop && head_op == SR_OP_WRITE) begin
			wr_app  <= head_app;
			wr_idx  <= head_idx;
			wr_data <= head_wdata;
		end
	end

	//----------------------------------------------------------------------
	// Application banks
	//----------------------------------------------------------------------
	assign bank_idx = wr_pend ? wr_idx : head_idx;

	for (genvar g = 0; g < NUM_APPS; g++) begin : app
		app_reg_bank #(.REGS_PER_APP(REGS_PER_APP)) bank0 (
			.global_clk(global_clk),
			.rst_n(rst_n),
			.wr_en(wr_pend && (wr_app == APP_W'(g))),
			.reg_idx(bank_idx),
			.wr_data(wr_data),
			.rd_data(bank_rd[g])
		);
	end

endmodule

`default_nettype wire

/* hdl/sr_req_fifo.sv */
/*
	Soft-register request FIFO

	Circular buffer of stored requests between the entry stage and the
	routing stage. There is no full check since the entry stage only
	pushes while it holds a credit. The head is read combinationally.
*/

`timescale 1ns/1ps
`default_nettype none

module sr_req_fifo import softreg_pkg::*; #(
	parameter int FIFO_DEPTH = 4
) (
	input  wire logic                 global_clk,
	input  wire logic                 rst_n,
	// Push side
	input  wire logic                 push,
	input  wire sr_op_e               push_op,
	input  wire logic [SR_ADDR_W-1:0] push_addr,
	input  wire logic [SR_DATA_W-1:0] push_wdata,
	// Pop side
	input  wire logic                 pop,
	output logic                      fifo_valid,
	output sr_op_e                    head_op,
	output logic [SR_ADDR_W-1:0]      head_addr,
	output logic [SR_DATA_W-1:0]      head_wdata
);

	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	logic [SR_REQ_W-1:0] mem [FIFO_DEPTH];
	logic [PTR_W-1:0]    wr_ptr;
	logic [PTR_W-1:0]    rd_ptr;
	logic [CNT_W-1:0]    count;
	logic [SR_REQ_W-1:0] head_entry;

	//----------------------------------------------------------------------
	// Pointers and occupancy
	//----------------------------------------------------------------------
	always_ff @(posedge global_clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Storage, packed as opcode, address, data
	always_ff @(posedge global_clk) begin
		if (push) begin
			mem[wr_ptr] <= {push_op, push_addr, push_wdata};
		end
	end

	//----------------------------------------------------------------------
	// Head of queue
	//----------------------------------------------------------------------
	assign fifo_valid = (count != '0);
	assign head_entry = mem[rd_ptr];
	assign head_op    = sr_op_e'(head_entry[SR_REQ_W-1]);
	assign head_addr  = head_entry[SR_DATA_W +: SR_ADDR_W];
	assign head_wdata = head_entry[SR_DATA_W-1:0];

endmodule

`default_nettype wire

/* hdl/sr_entry.sv */
/*
	Soft-register entry stage

	Accepts one host request at a time, turns it into an opcode and
	pushes it into the request FIFO one cycle later. Holds the credit
	count for the FIFO, so req_ready drops once all entries are in use.
*/

`timescale 1ns/1ps
`default_nettype none

module sr_entry import softreg_pkg::*; #(
	parameter int FIFO_DEPTH = 4
) (
	input  wire logic                 global_clk,
	input  wire logic                 rst_n,
	// Host request port
	input  wire logic                 req_valid,
	input  wire logic                 req_write,
	input  wire logic [SR_ADDR_W-1:0] req_addr,
	input  wire logic [SR_DATA_W-1:0] req_wdata,
	output logic                      req_ready,
	// Credit returned by the routing stage on each pop
	input  wire logic                 credit_return,
	// Push side of the request FIFO
	output logic                      push,
	output sr_op_e                    push_op,
	output logic [SR_ADDR_W-1:0]      push_addr,
	output logic [SR_DATA_W-1:0]      push_wdata
);

	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	logic [CNT_W-1:0] credits;
	logic             accept;

	assign req_ready = (credits != '0);
	assign accept    = req_valid && req_ready;

	// Take a credit on accept, give one back on return
	always_ff @(posedge global_clk or negedge rst_n) begin
		if (!rst_n) begin
			credits <= CNT_W'(FIFO_DEPTH);
		end else begin
			case ({accept, credit_return})
				2'b10:   credits <= credits - 1'b1;
				2'b01:   credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
		end
	end

	always_ff @(posedge global_clk or negedge rst_n) begin
		if (!rst_n) begin
			push <= 1'b0;
		end else begin
			push <= accept;
		end
	end

	// Request fields, only meaningful while push is high
	always_ff @(posedge global_clk) begin
		if (accept) begin
			push_op    <= req_write ? SR_OP_WRITE : SR_OP_READ;
			push_addr  <= req_addr;
			push_wdata <= req_wdata;
		end
	end

endmodule

`default_nettype wire

/* hdl/app_reg_bank.sv */
/*
	Application register bank

	REGS_PER_APP registers of one application. Written on wr_en at the
	clock edge, read combinationally through the same index.
*/

`timescale 1ns/1ps
`default_nettype none

module app_reg_bank import softreg_pkg::*; #(
	parameter int REGS_PER_APP = 8
) (
	input  wire logic                 global_clk,
	input  wire logic                 rst_n,
	input  wire logic                 wr_en,
	input  wire logic [$clog2(REGS_PER_APP > 1 ? REGS_PER_APP : 2)-1:0] reg_idx,
	input  wire logic [SR_DATA_W-1:0] wr_data,
	output logic [SR_DATA_W-1:0]      rd_data
);

	logic [SR_DATA_W-1:0] regs [REGS_PER_APP];

	// Register file with one write port
	always_ff @(posedge global_clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < REGS_PER_APP; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[reg_idx] <= wr_data;
		end
	end

	assign rd_data = regs[reg_idx];

endmodule

`default_nettype wire

/* hdl/softreg_pkg.sv */
/*
	Soft-register control path definitions

	Widths of the host request fields, the stored request word, the
	request opcode and the state encoding of the routing stage.
*/

`default_nettype none

package softreg_pkg;

	//----------------------------------------------------------------------
	// Field widths
	//----------------------------------------------------------------------

	// Host address and register data
	localparam int SR_ADDR_W = 32;
	localparam int SR_DATA_W = 64;

	// One stored request is opcode, address and data
	localparam int SR_REQ_W = 1 + SR_ADDR_W + SR_DATA_W;

	//----------------------------------------------------------------------
	// Encodings
	//----------------------------------------------------------------------

	// Request opcode, top bit of a stored request
	typedef enum logic {
		SR_OP_READ  = 1'b0,
		SR_OP_WRITE = 1'b1
	} sr_op_e;

	// Routing stage, idle or holding a read response for the host
	typedef enum logic {
		ROUTE_IDLE      = 1'b0,
		ROUTE_RESP_HOLD = 1'b1
	} sr_route_state_e;

endpackage

`default_nettype wire
